//--- common/ro_pkg.sv
`default_nettype none

package ro_pkg;

   // cache line geometry, 64-bit elements
   localparam int LINE_ELEMS     = 8;
   localparam int LOG_LINE_ELEMS = 3;

   localparam int N_THREADS     = 8;  // reads in flight
   localparam int LOG_N_THREADS = 3;

   localparam int N_ARIDS     = 16;   // bursts in flight
   localparam int LOG_N_ARIDS = 4;

   localparam int MAX_ELEMS = 32;     // largest single read

   typedef logic [31:0]              addr_t;   // byte address
   typedef logic [511:0]             line_t;
   typedef logic [63:0]              elem_t;
   typedef logic [7:0]               id_t;     // low LOG_N_ARIDS bits index the table
   typedef logic [LOG_N_THREADS-1:0] thread_id_t;
   typedef logic [7:0]               count_t;  // element count or index
   typedef logic [15:0]              tag_t;
   typedef logic [LINE_ELEMS-1:0]    slot_mask_t;

   typedef struct packed {
      addr_t  addr;
      count_t n_elems;
      tag_t   tag;
   } ro_req_t;

   // one record per outstanding burst
   typedef struct packed {
      thread_id_t thread;
      slot_mask_t slots;       // slots of the line that belong to the read
      count_t     start_elem;  // element index of the lowest slot
   } ro_mshr_t;

   typedef struct packed {
      tag_t   tag;
      count_t elem_id;
      elem_t  data;
   } ro_out_t;

endpackage

`default_nettype wire

//--- hw/free_list.sv
`timescale 1ns/100ps
`default_nettype none

// circular buffer of free indices, holds all of them after reset
module free_list #(
   parameter int LOG_DEPTH = 4
) (
   input  logic                 clk,
   input  logic                 rstn,

   input  logic                 push,
   input  logic [LOG_DEPTH-1:0] push_idx,
   input  logic                 pop,

   output logic [LOG_DEPTH-1:0] head,
   output logic                 empty,
   output logic                 full
);

logic [LOG_DEPTH-1:0] mem [0:2**LOG_DEPTH-1];
logic [LOG_DEPTH-1:0] rd_ptr;
logic [LOG_DEPTH-1:0] wr_ptr;
logic [LOG_DEPTH:0]   count;

always_ff @(posedge clk) begin
   if (!rstn) begin
      for (int i = 0; i < 2**LOG_DEPTH; i++) begin
         mem[i] <= LOG_DEPTH'(i);
      end
      rd_ptr <= '0;
      wr_ptr <= '0;  // wraps onto rd_ptr, buffer is full
      count  <= (LOG_DEPTH+1)'(2**LOG_DEPTH);
   end else begin
      if (push) begin
         mem[wr_ptr] <= push_idx;
         wr_ptr      <= wr_ptr + 1'b1;
      end
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
   end
end

assign head  = mem[rd_ptr];
assign empty = (count == '0);
assign full  = (count == (LOG_DEPTH+1)'(2**LOG_DEPTH));

endmodule

`default_nettype wire

//--- hw/ro_req/ro_burst_splitter.sv
`timescale 1ns/100ps
`default_nettype none

module ro_burst_splitter import ro_pkg::*; (
   input  logic       clk,
   input  logic       rstn,

   input  logic       req_valid,
   output logic       req_ready,
   input  ro_req_t    req,

   input  thread_id_t thread_head,
   input  logic       thread_empty,
   output logic       thread_pop,

   input  id_t        id_head,
   input  logic       id_empty,
   output logic       id_pop,

   output logic       arvalid,
   input  logic       arready,
   output addr_t      araddr,
   output id_t        arid,

   output logic       new_valid,
   output thread_id_t new_thread,
   output tag_t       new_tag,
   output count_t     new_n_elems,

   input  id_t        rid_lookup,
   output ro_mshr_t   rid_mshr
);

typedef enum logic {
   S_IDLE,
   S_ISSUE
} state_t;

state_t     state;
addr_t      cur_addr;
count_t     remaining;   // elements not yet issued
count_t     issued;      // elements issued so far
thread_id_t cur_thread;

logic [LOG_LINE_ELEMS-1:0] slot_first;
count_t     room;
count_t     burst_elems;
logic       last_burst;
logic       accept;
logic       ar_fire;
slot_mask_t burst_slots;
ro_mshr_t   mshr_table [0:N_ARIDS-1];

assign slot_first  = cur_addr[3 +: LOG_LINE_ELEMS];  // 8 bytes per element
assign room        = count_t'(LINE_ELEMS) - count_t'(slot_first);
assign burst_elems = (remaining < room) ? remaining : room;
assign last_burst  = (remaining <= room);

always_comb begin
   for (int i = 0; i < LINE_ELEMS; i++) begin
      burst_slots[i] = (count_t'(i) >= count_t'(slot_first)) &&
                       (count_t'(i) <  count_t'(slot_first) + burst_elems);
   end
end

assign arvalid = (state == S_ISSUE) && !id_empty;
assign araddr  = cur_addr;
assign arid    = id_head;
assign ar_fire = arvalid && arready;
assign id_pop  = ar_fire;

// a new read may enter on the cycle the final burst of the old one goes out
assign req_ready  = !thread_empty && ((state == S_IDLE) || (ar_fire && last_burst));
assign accept     = req_valid && req_ready;
assign thread_pop = accept;

assign new_valid   = accept;
assign new_thread  = thread_head;
assign new_tag     = req.tag;
assign new_n_elems = req.n_elems;

always_ff @(posedge clk) begin
   if (!rstn) begin
      state <= S_IDLE;
   end else if (accept) begin
      state <= S_ISSUE;
   end else if (ar_fire && last_burst) begin
      state <= S_IDLE;
   end
end

always_ff @(posedge clk) begin
   if (accept) begin
      cur_addr   <= req.addr;
      remaining  <= req.n_elems;
      issued     <= '0;
      cur_thread <= thread_head;
   end else if (ar_fire) begin
      cur_addr  <= cur_addr + (addr_t'(burst_elems) << 3);
      remaining <= remaining - burst_elems;
      issued    <= issued + burst_elems;
   end
end

always_ff @(posedge clk) begin
   if (ar_fire) begin
      mshr_table[arid[LOG_N_ARIDS-1:0]] <= '{thread: cur_thread,
                                             slots: burst_slots,
                                             start_elem: issued};
   end
end

assign rid_mshr = mshr_table[rid_lookup[LOG_N_ARIDS-1:0]];

endmodule

`default_nettype wire

//--- hw/ro_resp/ro_line_unpacker.sv
`timescale 1ns/100ps
`default_nettype none

module ro_line_unpacker import ro_pkg::*; (
   input  logic       clk,
   input  logic       rstn,

   input  logic       new_valid,
   input  thread_id_t new_thread,
   input  tag_t       new_tag,
   input  count_t     new_n_elems,

   input  logic       rvalid,
   output logic       rready,
   input  id_t        rid,
   input  line_t      rdata,

   output id_t        rid_lookup,
   input  ro_mshr_t   rid_mshr,

   output logic       id_push,
   output id_t        id_push_idx,

   output logic       thread_push,
   output thread_id_t thread_push_idx,

   output logic       out_valid,
   input  logic       out_ready,
   output ro_out_t    out
);

logic       line_valid;  // a line is held
line_t      line_data;
slot_mask_t cur_slots;   // slots still to send
thread_id_t cur_thread;
count_t     cur_elem;

tag_t   tag_table [0:N_THREADS-1];
count_t remaining [0:N_THREADS-1];  // elements left per thread

logic [LOG_LINE_ELEMS-1:0] slot_idx;
slot_mask_t next_slots;
logic       beat;
logic       line_done;
logic       r_fire;
logic       last_elem;

// lowest pending slot goes first
always_comb begin
   slot_idx = '0;
   for (int i = LINE_ELEMS-1; i >= 0; i--) begin
      if (cur_slots[i]) slot_idx = LOG_LINE_ELEMS'(i);
   end
end

assign next_slots = cur_slots & ~(slot_mask_t'(1) << slot_idx);
assign beat       = out_valid && out_ready;
assign line_done  = beat && (next_slots == '0);
assign rready     = !line_valid || line_done;
assign r_fire     = rvalid && rready;

assign rid_lookup  = rid;
assign id_push     = r_fire;
assign id_push_idx = rid;

assign out_valid   = line_valid;
assign out.tag     = tag_table[cur_thread];
assign out.elem_id = cur_elem;
assign out.data    = line_data[slot_idx*$bits(elem_t) +: $bits(elem_t)];

assign last_elem       = (remaining[cur_thread] == count_t'(1));
assign thread_push     = beat && last_elem;  // read fully delivered
assign thread_push_idx = cur_thread;

always_ff @(posedge clk) begin
   if (!rstn) begin
      line_valid <= 1'b0;
   end else if (r_fire) begin
      line_valid <= 1'b1;
   end else if (line_done) begin
      line_valid <= 1'b0;
   end
end

always_ff @(posedge clk) begin
   if (r_fire) begin
      line_data  <= rdata;
      cur_slots  <= rid_mshr.slots;
      cur_thread <= rid_mshr.thread;
      cur_elem   <= rid_mshr.start_elem;
   end else if (beat) begin
      cur_slots <= next_slots;
      cur_elem  <= cur_elem + 1'b1;
   end
end

always_ff @(posedge clk) begin
   if (new_valid) tag_table[new_thread] <= new_tag;
end

// a fresh thread never matches the one being drained
always_ff @(posedge clk) begin
   if (!rstn) begin
      for (int t = 0; t < N_THREADS; t++) begin
         remaining[t] <= '0;
      end
   end else begin
      for (int t = 0; t < N_THREADS; t++) begin
         if (new_valid && new_thread == thread_id_t'(t)) begin
            remaining[t] <= new_n_elems;
         end else if (beat && cur_thread == thread_id_t'(t)) begin
            remaining[t] <= remaining[t] - 1'b1;
         end
      end
   end
end

endmodule

`default_nettype wire

//--- hw/read_only_stage.sv
`timescale 1ns/100ps
`default_nettype none

module read_only_stage import ro_pkg::*; (
   input  logic    clk,
   input  logic    rstn,

   input  logic    req_valid,
   output logic    req_ready,
   input  ro_req_t req,

   output logic    arvalid,
   input  logic    arready,
   output addr_t   araddr,
   output id_t     arid,

   input  logic    rvalid,
   output logic    rready,
   input  id_t     rid,
   input  line_t   rdata,

   output logic    out_valid,
   input  logic    out_ready,
   output ro_out_t out,

   output logic    idle  // every thread is back in its list
);

thread_id_t thread_head;
logic       thread_empty;
logic       thread_pop;
logic       thread_push;
thread_id_t thread_push_idx;

logic [LOG_N_ARIDS-1:0] id_list_head;
id_t        id_head;
logic       id_empty;
logic       id_pop;
logic       id_push;
id_t        id_push_idx;

logic       new_valid;
thread_id_t new_thread;
tag_t       new_tag;
count_t     new_n_elems;

id_t        rid_lookup;
ro_mshr_t   rid_mshr;

assign id_head = id_t'(id_list_head);  // upper id bits stay zero

ro_burst_splitter burst_splitter_i (
   .clk, .rstn,
   .req_valid, .req_ready, .req,
   .thread_head, .thread_empty, .thread_pop,
   .id_head, .id_empty, .id_pop,
   .arvalid, .arready, .araddr, .arid,
   .new_valid, .new_thread, .new_tag, .new_n_elems,
   .rid_lookup, .rid_mshr
);

ro_line_unpacker line_unpacker_i (
   .clk, .rstn,
   .new_valid, .new_thread, .new_tag, .new_n_elems,
   .rvalid, .rready, .rid, .rdata,
   .rid_lookup, .rid_mshr,
   .id_push, .id_push_idx,
   .thread_push, .thread_push_idx,
   .out_valid, .out_ready, .out
);

free_list #(.LOG_DEPTH(LOG_N_ARIDS)) free_list_id_i (
   .clk, .rstn,
   .push(id_push), .push_idx(id_push_idx[LOG_N_ARIDS-1:0]), .pop(id_pop),
   .head(id_list_head), .empty(id_empty), .full()
);

free_list #(.LOG_DEPTH(LOG_N_THREADS)) free_list_thread_i (
   .clk, .rstn,
   .push(thread_push), .push_idx(thread_push_idx), .pop(thread_pop),
   .head(thread_head), .empty(thread_empty), .full(idle)
);

endmodule

`default_nettype wire

//--- test/ro_stage_chk.sv
`timescale 1ns/100ps
`default_nettype none

module ro_stage_chk import ro_pkg::*; (
   input logic    clk,
   input logic    rstn,
   input logic    arvalid,
   input logic    arready,
   input addr_t   araddr,
   input id_t     arid,
   input logic    out_valid,
   input logic    out_ready,
   input ro_out_t out
);

int   fail_count = 0;
logic rst_prev;  // rstn low at the previous edge

always @(posedge clk) rst_prev <= !rstn;

ar_hold: assert property (@(posedge clk) disable iff (!rstn)
   arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
   else begin
      fail_count++;
      $error("read address dropped or changed before arready");
   end

out_hold: assert property (@(posedge clk) disable iff (!rstn)
   out_valid && !out_ready |=> out_valid && $stable(out))
   else begin
      fail_count++;
      $error("output element dropped or changed before out_ready");
   end

reset_quiet: assert property (@(posedge clk) !rstn && rst_prev |-> !arvalid && !out_valid)
   else begin
      fail_count++;
      $error("arvalid or out_valid high during reset");
   end

endmodule

bind read_only_stage ro_stage_chk ro_stage_chk_i (.*);

`default_nettype wire

//--- test/ro_stage_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module ro_stage_monitor import ro_pkg::*; (
   input  logic    clk,
   input  logic    rstn,
   input  logic    req_valid,
   input  logic    req_ready,
   input  logic    arvalid,
   input  logic    arready,
   input  addr_t   araddr,
   input  logic    out_valid,
   input  logic    out_ready,
   input  ro_out_t out,
   input  logic    idle,
   output int      err_count,
   output int      completed,
   output int      burst_count,
   output int      elem_count,
   output logic    done
);

localparam int MAX_REQS = 64;

logic [31:0] vec [0:4*MAX_REQS-1];  // addr, n_elems, tag, bursts per read
int   n_reqs;
int   accepted;
int   issued;       // elements issued for the newest accepted read
int   bursts [0:MAX_REQS-1];
int   got [0:MAX_REQS-1];
logic [MAX_ELEMS-1:0] seen [0:MAX_REQS-1];

initial begin
   for (int i = 0; i < 4*MAX_REQS; i++) vec[i] = '0;
   $readmemh("test/ro_stage_input.txt", vec);
   n_reqs = 0;
   while (n_reqs < MAX_REQS && vec[4*n_reqs+1] != '0) n_reqs++;
   for (int r = 0; r < MAX_REQS; r++) begin
      bursts[r] = 0;
      got[r]    = 0;
      seen[r]   = '0;
   end
   err_count   = 0;
   completed   = 0;
   burst_count = 0;
   elem_count  = 0;
   accepted    = 0;
   issued      = 0;
end

assign done = (n_reqs > 0) && (completed == n_reqs);

task automatic check_burst();
   int    r;
   int    take;
   addr_t exp_a;
   r = accepted - 1;  // the newest read is the one being split
   if (r < 0 || issued >= int'(vec[4*r+1])) begin
      err_count++;
      $display("address handshake while no read had elements left to issue");
      return;
   end
   exp_a = vec[4*r] + addr_t'(issued * 8);
   take  = LINE_ELEMS - int'(exp_a[5:3]);  // slots left in this line
   if (int'(vec[4*r+1]) - issued < take) take = int'(vec[4*r+1]) - issued;
   if (araddr !== exp_a) begin
      err_count++;
      $display("CHECK FAILED araddr: got %h expected %h", araddr, exp_a);
   end
   burst_count++;
   bursts[r]++;
   issued += take;
endtask

task automatic check_elem();
   int    r;
   addr_t a;
   elem_t exp_d;
   r = -1;
   for (int i = 0; i < accepted; i++) begin
      if (tag_t'(vec[4*i+2]) == out.tag) r = i;
   end
   if (r < 0) begin
      err_count++;
      $display("element arrived with tag %h, which no accepted read carries", out.tag);
      return;
   end
   elem_count++;
   if (out.elem_id >= count_t'(vec[4*r+1]) || seen[r][out.elem_id[4:0]]) begin
      err_count++;
      $display("CHECK FAILED out.elem_id of tag %h: got %h, repeated or not below %h",
               out.tag, out.elem_id, vec[4*r+1][7:0]);
      return;
   end
   seen[r][out.elem_id[4:0]] = 1'b1;
   a     = vec[4*r] + (addr_t'(out.elem_id) << 3);
   exp_d = {~a, a};
   if (out.data !== exp_d) begin
      err_count++;
      $display("CHECK FAILED out.data tag %h elem %h: got %h expected %h",
               out.tag, out.elem_id, out.data, exp_d);
   end
   got[r]++;
   if (got[r] == int'(vec[4*r+1])) begin
      completed++;
      // every line of the read is back, so all its bursts went out
      if (bursts[r] != int'(vec[4*r+3])) begin
         err_count++;
         $display("CHECK FAILED burst count of tag %h: got %h expected %h",
                  vec[4*r+2][15:0], bursts[r], vec[4*r+3]);
      end
   end
endtask

always @(posedge clk) begin
   if (rstn) begin
      // idle reflects reads finished at earlier edges
      if (idle !== (accepted == completed)) begin
         err_count++;
         $display("CHECK FAILED idle: got %h expected %h", idle, accepted == completed);
      end
      // a burst on the accepting edge still belongs to the older read
      if (arvalid && arready) check_burst();
      if (req_valid && req_ready) begin
         if (accepted < n_reqs) begin
            accepted++;
            issued = 0;
         end else begin
            err_count++;
            $display("a request was accepted beyond the end of the input file");
         end
      end
      if (out_valid && out_ready) check_elem();
   end
end

endmodule

`default_nettype wire

//--- test/ro_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ro_stage_tb import ro_pkg::*; ();

localparam int MAX_REQS   = 64;
localparam int CLK_PERIOD = 40;

logic    clk;
logic    rstn;
logic    req_valid;
logic    req_ready;
ro_req_t req;
logic    arvalid;
logic    arready;
addr_t   araddr;
id_t     arid;
logic    rvalid;
logic    rready;
id_t     rid;
line_t   rdata;
logic    out_valid;
logic    out_ready;
ro_out_t out;
logic    idle;

int   err_count;
int   completed;
int   burst_count;
int   elem_count;
logic done;
int   n_reqs;
int   limit_cycles;
logic [31:0] vec [0:4*MAX_REQS-1];

read_only_stage read_only_stage_i (.*);

ro_stage_monitor monitor_i (.*);

function automatic logic [31:0] lcg_next(input logic [31:0] s);
   return s * 32'd1664525 + 32'd1013904223;
endfunction

// element at byte address A holds {~A, A}
function automatic line_t build_line(input addr_t a);
   line_t l;
   addr_t e;
   for (int s = 0; s < LINE_ELEMS; s++) begin
      e = {a[31:6], 6'b0} + addr_t'(8 * s);
      l[64*s +: 64] = {~e, e};
   end
   return l;
endfunction

function automatic int total_errors();
   return err_count + read_only_stage_i.ro_stage_chk_i.fail_count;
endfunction

task automatic print_counts();
   $display("errors %0d (assertions %0d), reads done %0d of %0d, bursts %0d, elements %0d",
            total_errors(), read_only_stage_i.ro_stage_chk_i.fail_count,
            completed, n_reqs, burst_count, elem_count);
endtask

initial begin
   clk = 1'b0;
   forever #(CLK_PERIOD/2) clk = ~clk;
end

initial begin : requester
   rstn      = 1'b0;
   req_valid = 1'b0;
   req       = '0;
   for (int i = 0; i < 4*MAX_REQS; i++) vec[i] = '0;
   $readmemh("test/ro_stage_input.txt", vec);
   n_reqs       = 0;
   limit_cycles = 1000;
   while (n_reqs < MAX_REQS && vec[4*n_reqs+1] != '0) begin
      limit_cycles += 40 * int'(vec[4*n_reqs+1]);
      n_reqs++;
   end
   repeat (3) @(posedge clk);
   #1 rstn = 1'b1;
   for (int k = 0; k < n_reqs; k++) begin
      req_valid   = 1'b1;
      req.addr    = vec[4*k];
      req.n_elems = count_t'(vec[4*k+1]);
      req.tag     = tag_t'(vec[4*k+2]);
      do begin
         @(posedge clk);
      end while (!req_ready);
      #1;
   end
   req_valid = 1'b0;
   wait (done);
   repeat (20) @(posedge clk);  // room for stray elements and the idle check
   print_counts();
   if (total_errors() == 0) begin
      $display("ALL TESTS PASSED");
   end else begin
      $display("SOME TESTS FAILED");
   end
   $finish;
end

initial begin : memory_model
   logic [31:0] rng;
   addr_t pend_addr [$];
   id_t   pend_id [$];
   int    delay;
   int    pick;
   logic  ar_hs;
   logic  r_hs;
   rng       = 32'ha476_11aa;
   delay     = 0;
   arready   = 1'b0;
   rvalid    = 1'b0;
   rid       = '0;
   rdata     = '0;
   out_ready = 1'b0;
   forever begin
      @(posedge clk);
      ar_hs = arvalid && arready;
      r_hs  = rvalid && rready;
      if (ar_hs) begin
         pend_addr.push_back(araddr);
         pend_id.push_back(arid);
      end
      #1;
      rng       = lcg_next(rng);
      arready   = rstn && (rng[31:30] != 2'b00);
      out_ready = rstn && (rng[29:28] != 2'b00);
      if (r_hs) begin
         rvalid = 1'b0;
         delay  = (rng[27:25] == 3'd0) ? 30 : int'(rng[24:22]);  // a slow line now and then
      end
      if (!rvalid && pend_addr.size() > 0) begin
         if (delay > 0) begin
            delay--;
         end else begin
            rng    = lcg_next(rng);
            pick   = rng[31] ? pend_addr.size() - 1 : 0;  // newest or oldest burst
            rid    = pend_id[pick];
            rdata  = build_line(pend_addr[pick]);
            rvalid = 1'b1;
            pend_addr.delete(pick);
            pend_id.delete(pick);
         end
      end
   end
end

initial begin : watchdog
   wait (limit_cycles > 0);
   repeat (limit_cycles) @(posedge clk);
   $display("timeout after %0d cycles with only %0d of %0d reads finished",
            limit_cycles, completed, n_reqs);
   print_counts();
   $display("SOME TESTS FAILED");
   $finish;
end

endmodule

`default_nettype wire

//--- test/ro_stage_input.txt
// columns: start address, element count, tag, expected burst count (all hex)
// one read per line, the element count is never zero
00001000 08 0a01 1
00002008 08 0a02 2
00003038 01 0a03 1
00004010 14 0a04 3
00005000 20 0a05 4
00006038 02 0a06 2
00007008 20 0a07 5
00008020 04 0a08 1
00009018 0d 0a09 2
0000a000 10 0a0a 2
0000b030 0a 0a0b 2
0000c000 01 0a0c 1
0000d028 1b 0a0d 4

//--- all.f
common/ro_pkg.sv
hw/free_list.sv
hw/ro_req/ro_burst_splitter.sv
hw/ro_resp/ro_line_unpacker.sv
hw/read_only_stage.sv
test/ro_stage_chk.sv
test/ro_stage_monitor.sv
test/ro_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ro_stage_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS RUN_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@if grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
